//--- verilog/csr_cfg.svh
// csr addresses, performance counter count and reset values
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

//////////////////////////////////////////////////////////////////////
// machine trap registers
//////////////////////////////////////////////////////////////////////

`define CSR_MSTATUS_ADDR   12'h300
`define CSR_MTVEC_ADDR     12'h305
`define CSR_MEPC_ADDR      12'h341
`define CSR_MCAUSE_ADDR    12'h342
`define CSR_MHARTID_ADDR   12'hF14

// mstatus field positions
`define MSTATUS_MIE_BIT    3
`define MSTATUS_MPIE_BIT   7

// only machine mode exists
`define PRIV_LVL_M         2'b11

//////////////////////////////////////////////////////////////////////
// performance counters
//////////////////////////////////////////////////////////////////////

`define CSR_PCER_ADDR      12'h7A0
`define CSR_PCMR_ADDR      12'h7A1
`define CSR_PCCR_ALL_ADDR  12'h79F
// 32-entry counter window
`define CSR_PCCR_BASE      12'h780

`define PERF_N_CNT         11
// global enable and saturate set
`define PCMR_RESET         2'd3

`endif

//--- verilog/csr_pkg.sv
// csr vector types, operation enum and packed structs
`include "csr_cfg.svh"

package csr_pkg;

  // address and data of the csr port
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // csr instruction operation
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // bit 5 marks an interrupt, 4:0 is the code
  typedef logic [5:0] cause_t;

  // trap vector base, lower 8 bits are zero
  typedef logic [23:0] tvec_t;

  // one bit per counter
  typedef logic [`PERF_N_CNT-1:0] perf_vec_t;

  typedef struct packed {
    logic       mie;
    logic       mpie;
    logic [1:0] mpp;
  } mstatus_t;

  // from the controller on exceptions and interrupts
  typedef struct packed {
    logic      save_cause;
    logic      save_if;
    logic      save_id;
    cause_t    cause;
    csr_data_t pc_if;
    csr_data_t pc_id;
  } trap_req_t;

  // raw pipeline events
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } perf_raw_t;

endpackage

//--- verilog/csr_access_ctrl.sv
// csr read merge, hartid and mtvec decode, op-modified write data
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_access_ctrl (
  input  logic              csr_access_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  input  logic [3:0]        core_id_i,
  input  logic [5:0]        cluster_id_i,
  input  csr_pkg::tvec_t     boot_addr_i,
  input  csr_pkg::csr_data_t trap_rdata_i,
  input  csr_pkg::csr_data_t perf_rdata_i,
  input  logic              perf_hit_i,
  output csr_pkg::csr_data_t csr_rdata_o,
  output csr_pkg::csr_data_t wdata_o,
  output logic              we_o,
  output csr_pkg::tvec_t     mtvec_o
);

  import csr_pkg::*;

  csr_data_t local_rdata;

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  // read-only registers built from inputs
  always_comb begin
    case (csr_addr_i)
      // cluster id in 10:5, core id in 3:0
      `CSR_MHARTID_ADDR: local_rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
      // vector base from boot address
      `CSR_MTVEC_ADDR:   local_rdata = {boot_addr_i, 8'h00};
      default:           local_rdata = '0;
    endcase
  end

  // counter block wins when it claims the address
  assign csr_rdata_o = perf_hit_i ? perf_rdata_i : (trap_rdata_i | local_rdata);

  assign mtvec_o = boot_addr_i;

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // old value is the merged read data
  always_comb begin
    case (csr_op_i)
      CSR_OP_SET:   wdata_o = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: wdata_o = csr_rdata_o & ~csr_wdata_i;
      default:      wdata_o = csr_wdata_i;
    endcase
  end

  assign we_o = csr_access_i && (csr_op_i != CSR_OP_NONE);

  // controller must present a defined op with every access
  always_comb begin
    if (csr_access_i) begin
      assert (!$isunknown(csr_op_i))
        else $error("csr op unknown during access");
    end
  end

endmodule

//--- verilog/csr_trap_regs.sv
// mstatus, mepc and mcause with trap entry, mret and read decode
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_trap_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_data_t  wdata_i,
  input  logic                we_i,
  input  csr_pkg::trap_req_t  trap_i,
  input  logic                mret_i,
  output csr_pkg::csr_data_t  trap_rdata_o,
  output csr_pkg::csr_data_t  epc_o,
  output logic                m_irq_enable_o
);

  import csr_pkg::*;

  mstatus_t  mstatus_q, mstatus_d;
  csr_data_t mepc_q, mepc_d;
  cause_t    mcause_q, mcause_d;

  //////////////////////////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (csr_addr_i)
      // mpp 12:11, mpie 7, mie 3
      `CSR_MSTATUS_ADDR: trap_rdata_o = {19'b0, mstatus_q.mpp, 3'b0, mstatus_q.mpie,
                                         3'b0, mstatus_q.mie, 3'b0};
      `CSR_MEPC_ADDR:    trap_rdata_o = mepc_q;
      // interrupt flag moves up to bit 31
      `CSR_MCAUSE_ADDR:  trap_rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      default:           trap_rdata_o = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    // csr writes, dropped when a trap is taken
    if (we_i && !trap_i.save_cause) begin
      case (csr_addr_i)
        `CSR_MSTATUS_ADDR: begin
          mstatus_d.mie  = wdata_i[`MSTATUS_MIE_BIT];
          mstatus_d.mpie = wdata_i[`MSTATUS_MPIE_BIT];
        end
        `CSR_MEPC_ADDR:   mepc_d   = wdata_i;
        `CSR_MCAUSE_ADDR: mcause_d = {wdata_i[31], wdata_i[4:0]};
        default: ;
      endcase
    end

    // trap entry first, then mret
    if (trap_i.save_cause) begin
      mepc_d         = trap_i.save_if ? trap_i.pc_if : trap_i.pc_id;
      mcause_d       = trap_i.cause;
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
    end else if (mret_i) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end

    // always machine mode
    mstatus_d.mpp = `PRIV_LVL_M;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '{mie: 1'b0, mpie: 1'b0, mpp: `PRIV_LVL_M};
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  assign epc_o          = mepc_q;
  assign m_irq_enable_o = mstatus_q.mie;

  // controller selects exactly one pc source
  assert property (@(posedge clk) disable iff (!rst_n)
    !(trap_i.save_if && trap_i.save_id));

  // controller never retires mret while entering a trap
  assert property (@(posedge clk) disable iff (!rst_n)
    !(trap_i.save_cause && mret_i));

endmodule

//--- verilog/perf_event_gen.sv
// conditioning of raw pipeline events into counter increment requests
`timescale 1ns/10ps

module perf_event_gen (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::perf_raw_t perf_raw_i,
  output csr_pkg::perf_vec_t events_o
);

  logic id_valid_q;
  logic instr_done;

  // stall and branch info relates to the previous id cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else begin
      id_valid_q <= perf_raw_i.id_valid;
    end
  end

  // instruction leaves id while decoding
  assign instr_done = perf_raw_i.id_valid & perf_raw_i.is_decoding;

  // cycles
  assign events_o[0]  = 1'b1;
  assign events_o[1]  = instr_done;
  // load-use and jump-register hazards
  assign events_o[2]  = perf_raw_i.ld_stall & id_valid_q;
  assign events_o[3]  = perf_raw_i.jr_stall & id_valid_q;
  // fetch wait, jumps and branches excluded
  assign events_o[4]  = perf_raw_i.imiss & ~perf_raw_i.pc_set;
  assign events_o[5]  = perf_raw_i.mem_load;
  assign events_o[6]  = perf_raw_i.mem_store;
  assign events_o[7]  = perf_raw_i.jump & id_valid_q;
  assign events_o[8]  = perf_raw_i.branch & id_valid_q;
  assign events_o[9]  = perf_raw_i.branch & perf_raw_i.branch_taken & id_valid_q;
  // compressed instructions
  assign events_o[10] = instr_done & perf_raw_i.is_compressed;

endmodule

//--- verilog/perf_counters.sv
// pcer, pcmr and counter bank with decode, saturation and read data
`timescale 1ns/10ps
`include "csr_cfg.svh"

module perf_counters (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               csr_access_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t wdata_i,
  input  logic               we_i,
  input  csr_pkg::perf_vec_t events_i,
  output csr_pkg::csr_data_t perf_rdata_o,
  output logic               perf_hit_o
);

  import csr_pkg::*;

  localparam csr_addr_t PCCR_BASE = `CSR_PCCR_BASE;

  logic        is_pcer;
  logic        is_pcmr;
  logic        is_win;
  logic        all_sel;
  logic [4:0]  cnt_idx;
  perf_vec_t   pcer_q;
  logic [1:0]  pcmr_q;
  perf_vec_t   inc_q;
  perf_vec_t   cnt_we;
  csr_data_t   cnt_q [`PERF_N_CNT];

  //////////////////////////////////////////////////////////////////////
  // address decode and read data
  //////////////////////////////////////////////////////////////////////

  assign is_pcer = csr_access_i && (csr_addr_i == `CSR_PCER_ADDR);
  assign is_pcmr = csr_access_i && (csr_addr_i == `CSR_PCMR_ADDR);
  // window also covers the all-counter address
  assign is_win  = csr_access_i && (csr_addr_i[11:5] == PCCR_BASE[11:5]);
  assign all_sel = csr_addr_i == `CSR_PCCR_ALL_ADDR;
  assign cnt_idx = csr_addr_i[4:0];

  assign perf_hit_o = is_pcer || is_pcmr || is_win;

  always_comb begin
    perf_rdata_o = '0;
    if (is_pcer) begin
      perf_rdata_o[`PERF_N_CNT-1:0] = pcer_q;
    end
    if (is_pcmr) begin
      perf_rdata_o[1:0] = pcmr_q;
    end
    // unused window slots read zero
    if (is_win) begin
      for (int i = 0; i < `PERF_N_CNT; i++) begin
        if (cnt_idx == 5'(i)) begin
          perf_rdata_o = cnt_q[i];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // mode and enable registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= `PCMR_RESET;
      inc_q  <= '0;
    end else begin
      if (we_i && is_pcer) begin
        pcer_q <= wdata_i[`PERF_N_CNT-1:0];
      end
      if (we_i && is_pcmr) begin
        pcmr_q <= wdata_i[1:0];
      end
      // request lands one edge ahead of the count
      inc_q <= events_i & pcer_q & {`PERF_N_CNT{pcmr_q[0]}};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // counter bank
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `PERF_N_CNT; i++) begin : g_cnt
    assign cnt_we[i] = we_i && is_win && (all_sel || (cnt_idx == 5'(i)));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q[i] <= '0;
      end else if (cnt_we[i]) begin
        // write beats a pending increment
        cnt_q[i] <= wdata_i;
      end else if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1])) begin
        cnt_q[i] <= cnt_q[i] + 32'd1;
      end
    end

    // counts by at most one per cycle, wrap included
    assert property (@(posedge clk) disable iff (!rst_n)
      !cnt_we[i] |=> (csr_data_t'(cnt_q[i] - $past(cnt_q[i])) <= 32'd1));
  end

endmodule

//--- verilog/csr_top.sv
// machine-mode csr block top level
`timescale 1ns/10ps

module csr_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [3:0]         core_id_i,
  input  logic [5:0]         cluster_id_i,
  input  csr_pkg::tvec_t     boot_addr_i,
  input  logic               csr_access_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  output csr_pkg::csr_data_t csr_rdata_o,
  input  csr_pkg::trap_req_t trap_i,
  input  logic               mret_i,
  output csr_pkg::csr_data_t epc_o,
  output csr_pkg::tvec_t     mtvec_o,
  output logic               m_irq_enable_o,
  input  csr_pkg::perf_raw_t perf_raw_i
);

  import csr_pkg::*;

  // merged write value to both register units
  csr_data_t wdata;
  logic      we;
  // read data back to the merge
  csr_data_t trap_rdata;
  csr_data_t perf_rdata;
  logic      perf_hit;
  perf_vec_t events;

  csr_access_ctrl u_access_ctrl (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_op_i     (csr_op_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .boot_addr_i  (boot_addr_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .perf_hit_i   (perf_hit),
    .csr_rdata_o  (csr_rdata_o),
    .wdata_o      (wdata),
    .we_o         (we),
    .mtvec_o      (mtvec_o)
  );

  csr_trap_regs u_trap_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_addr_i     (csr_addr_i),
    .wdata_i        (wdata),
    .we_i           (we),
    .trap_i         (trap_i),
    .mret_i         (mret_i),
    .trap_rdata_o   (trap_rdata),
    .epc_o          (epc_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  perf_event_gen u_event_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .perf_raw_i (perf_raw_i),
    .events_o   (events)
  );

  perf_counters u_counters (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .wdata_i      (wdata),
    .we_i         (we),
    .events_i     (events),
    .perf_rdata_o (perf_rdata),
    .perf_hit_o   (perf_hit)
  );

endmodule

//--- tb/csr_tb.sv
// csr block testbench with clock, reset, stimulus reader, compare tasks and watchdog
`timescale 1ns/10ps

module csr_tb;

  import csr_pkg::*;

  localparam int    CLK_HALF   = 2;
  localparam int    RST_CYCLES = 16;
  localparam int    MARGIN     = 50;
  localparam string STIM_FILE  = "tb/csr_stimulus.txt";

  logic       clk;
  logic       rst_n;
  logic [3:0] core_id;
  logic [5:0] cluster_id;
  tvec_t      boot_addr;
  logic       csr_access;
  csr_addr_t  csr_addr;
  csr_data_t  csr_wdata;
  csr_op_e    csr_op;
  csr_data_t  csr_rdata;
  trap_req_t  trap;
  logic       mret;
  csr_data_t  epc;
  tvec_t      mtvec;
  logic       m_irq_enable;
  perf_raw_t  perf_raw;

  // operands of the current stimulus line
  csr_data_t  arg [7];
  int         budget_cycles;
  logic       budget_ready;
  int         check_count;

  csr_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_id_i      (core_id),
    .cluster_id_i   (cluster_id),
    .boot_addr_i    (boot_addr),
    .csr_access_i   (csr_access),
    .csr_addr_i     (csr_addr),
    .csr_wdata_i    (csr_wdata),
    .csr_op_i       (csr_op),
    .csr_rdata_o    (csr_rdata),
    .trap_i         (trap),
    .mret_i         (mret),
    .epc_o          (epc),
    .mtvec_o        (mtvec),
    .m_irq_enable_o (m_irq_enable),
    .perf_raw_i     (perf_raw)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
    check_count++;
    if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_tvec(input string name, input tvec_t got, input tvec_t exp);
    check_count++;
    if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s got 0x%06h expected 0x%06h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus file parsing
  //////////////////////////////////////////////////////////////////////

  // operands per command letter, -1 for unknown letters
  function automatic int field_count(input logic [7:0] cmd);
    case (cmd)
      "A", "P": return 3;
      "R", "N": return 2;
      "T":      return 7;
      "E", "I": return 1;
      "M":      return 0;
      default:  return -1;
    endcase
  endfunction

  task automatic read_command(input int fd, output logic [7:0] cmd, output logic got);
    int         c;
    int         rc;
    logic [7:0] ch;
    got = 1'b0;
    cmd = 8'h00;
    for (int i = 0; i < 7; i++) begin
      arg[i] = '0;
    end
    c = $fgetc(fd);
    while (c != -1 && !got) begin
      ch = 8'(c);
      if (ch == "#") begin
        // comment runs to end of line
        while (c != -1 && 8'(c) != 8'h0A) begin
          c = $fgetc(fd);
        end
      end else if (ch == " " || ch == 8'h0A || ch == 8'h0D || ch == 8'h09) begin
        c = $fgetc(fd);
      end else begin
        cmd = ch;
        got = 1'b1;
      end
    end
    if (got) begin
      if (field_count(cmd) < 0) begin
        fail_stop($sformatf("unknown command letter '%c' in stimulus file", cmd));
      end
      for (int i = 0; i < field_count(cmd); i++) begin
        rc = $fscanf(fd, " %h", arg[i]);
        if (rc != 1) begin
          fail_stop($sformatf("missing operand for command '%c' in stimulus file", cmd));
        end
      end
    end
  endtask

  // cycle budget for the watchdog, one pass over the file
  task automatic count_cycles();
    int         fd;
    logic [7:0] cmd;
    logic       got;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      fail_stop("could not open the stimulus file");
    end
    budget_cycles = 0;
    got = 1'b1;
    while (got) begin
      read_command(fd, cmd, got);
      if (got) begin
        budget_cycles += (cmd == "N") ? int'(arg[0]) : 1;
      end
    end
    $fclose(fd);
    budget_ready = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////////////////////////

  // every cycle starts idle, commands override
  task automatic start_cycle();
    @(posedge clk);
    csr_access <= 1'b0;
    csr_op     <= CSR_OP_NONE;
    trap       <= '0;
    mret       <= 1'b0;
    perf_raw   <= '0;
  endtask

  task automatic drive_access(input csr_data_t op, input csr_data_t addr, input csr_data_t data);
    csr_access <= 1'b1;
    csr_op     <= csr_op_e'(op[1:0]);
    csr_addr   <= addr[11:0];
    csr_wdata  <= data;
  endtask

  task automatic run_command(input logic [7:0] cmd);
    trap_req_t req;
    case (cmd)
      "P": begin
        start_cycle();
        core_id    <= arg[0][3:0];
        cluster_id <= arg[1][5:0];
        boot_addr  <= arg[2][23:0];
        // trap vector output is the boot address itself
        @(negedge clk);
        check_tvec("mtvec_o", mtvec, tvec_t'(arg[2][23:0]));
      end
      "A": begin
        start_cycle();
        drive_access(arg[0], arg[1], arg[2]);
      end
      "R": begin
        start_cycle();
        csr_access <= 1'b1;
        csr_addr   <= arg[0][11:0];
        // combinational read, settled by the falling edge
        @(negedge clk);
        check_data($sformatf("csr_rdata_o[0x%03h]", arg[0][11:0]), csr_rdata, arg[1]);
      end
      "T": begin
        req.save_cause = 1'b1;
        req.save_if    = arg[1][0];
        req.save_id    = !arg[1][0];
        req.cause      = arg[0][5:0];
        req.pc_if      = arg[2];
        req.pc_id      = arg[3];
        start_cycle();
        trap <= req;
        // optional csr access in the trap cycle
        if (arg[4][1:0] != 2'b00) begin
          drive_access(arg[4], arg[5], arg[6]);
        end
      end
      "M": begin
        start_cycle();
        mret <= 1'b1;
      end
      "N": begin
        for (int i = 0; i < int'(arg[0]); i++) begin
          start_cycle();
          perf_raw <= perf_raw_t'(arg[1][11:0]);
        end
      end
      "E": begin
        start_cycle();
        @(negedge clk);
        check_data("epc_o", epc, arg[0]);
      end
      "I": begin
        start_cycle();
        @(negedge clk);
        check_bit("m_irq_enable_o", m_irq_enable, arg[0][0]);
      end
      default: begin
        fail_stop($sformatf("cannot execute command letter '%c'", cmd));
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    int         fd;
    logic [7:0] cmd;
    logic       got;
    rst_n        = 1'b0;
    core_id      = '0;
    cluster_id   = '0;
    boot_addr    = '0;
    csr_access   = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    csr_op       = CSR_OP_NONE;
    trap         = '0;
    mret         = 1'b0;
    perf_raw     = '0;
    check_count  = 0;
    budget_ready = 1'b0;
    count_cycles();
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen(STIM_FILE, "r");
    got = 1'b1;
    while (got) begin
      read_command(fd, cmd, got);
      if (got) begin
        run_command(cmd);
      end
    end
    $fclose(fd);
    start_cycle();
    if (check_count > 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      fail_stop("stimulus file held no checks");
    end
  end

  initial begin : watchdog
    wait (budget_ready);
    repeat (budget_cycles + RST_CYCLES + MARGIN) @(posedge clk);
    fail_stop($sformatf("timeout, stimulus not done after %0d cycles",
                        budget_cycles + RST_CYCLES + MARGIN));
  end

endmodule

//--- tb/csr_stimulus.txt
# cmd letter then hex operands, one command per line, each command one cycle except N
# P core cluster boot | A op addr data | R addr expected | T cause sel(1=if) pc_if pc_id op addr data
# M (mret) | N cycles raw_events | E expected_epc | I expected_irq_enable
P 5 2A 1C0080
# reset values
R 300 00001800
R 7A1 00000003
R 7A0 00000000
R 341 00000000
R 342 00000000
R 305 1C008000
R F14 00000545
I 0
# write, set, clear and no-op on mepc
A 1 341 12345678
R 341 12345678
A 2 341 0000F00F
R 341 1234F67F
A 3 341 000000FF
R 341 1234F600
A 0 341 FFFFFFFF
R 341 1234F600
# mie through mstatus
A 2 300 00000008
R 300 00001808
I 1
A 3 300 00000008
R 300 00001800
I 0
A 1 300 00000088
R 300 00001888
I 1
A 0 300 00000000
R 300 00001888
# trap entry from if, then from id with a lost write
T 2B 1 00000400 00000404 0 000 00000000
R 341 00000400
E 00000400
R 342 8000000B
R 300 00001880
I 0
T 02 0 00000500 00000504 1 341 DEADBEEF
R 341 00000504
E 00000504
R 342 00000002
R 300 00001800
# mret twice
M
I 0
R 300 00001880
M
I 1
R 300 00001888
# cycle counter
A 1 7A0 00000001
A 1 780 00000000
R 780 00000000
R 780 00000001
R 780 00000002
N 3 000
R 780 00000006
# saturate, then wrap with pcmr 1
A 1 780 FFFFFFFD
R 780 FFFFFFFD
R 780 FFFFFFFE
R 780 FFFFFFFF
R 780 FFFFFFFF
A 1 7A1 00000001
R 780 FFFFFFFF
R 780 00000000
R 780 00000001
R 7A1 00000001
A 1 7A1 00000003
# instruction and taken-branch counters, branch counter disabled
A 1 7A0 00000203
R 7A0 00000203
N 5 C30
N 2 C00
N 2 030
N 3 000
R 781 00000007
R 789 00000005
R 788 00000000
R 78A 00000000
R 790 00000000
# all-counter write
A 1 79F 00000000
R 780 00000000
R 781 00000000
R 789 00000000

//--- project.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_access_ctrl.sv
verilog/csr_trap_regs.sv
verilog/perf_event_gen.sv
verilog/perf_counters.sv
verilog/csr_top.sv
tb/csr_tb.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= csr_tb
FILELIST ?= project.f

PASS_MSG := ALL TESTS PASSED
SIM      := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
